//--- source/mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// ********************
// datapath and register file sizes

`define MIPS_XLEN      32   // data width
`define MIPS_REG_COUNT 32   // architectural registers
`define MIPS_REG_BITS  5    // register index width

// ********************
// fixed register numbers

`define MIPS_LINK_REG  31   // jal return address

`endif

//--- source/mips_pkg.sv
package mips_pkg;

    // ********************
    // primary opcodes, instr[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,   // r-type, see funct
        OP_JAL     = 6'h03,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f
    } opcode_e;

    // r-type function codes, instr[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    // ********************
    // internal control
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic {
        WB_ALU  = 1'b0,
        WB_LINK = 1'b1        // pc + 8 for jal
    } wb_src_e;

endpackage

//--- source/mips_register_file.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module mips_register_file (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      wr_en,
    input  logic [`MIPS_REG_BITS-1:0] wr_reg,
    input  logic [`MIPS_XLEN-1:0]     wr_data,
    input  logic [`MIPS_REG_BITS-1:0] rd_a_reg,
    input  logic [`MIPS_REG_BITS-1:0] rd_b_reg,
    output logic [`MIPS_XLEN-1:0]     rd_a_data,
    output logic [`MIPS_XLEN-1:0]     rd_b_data
);

    logic [`MIPS_XLEN-1:0] regs [`MIPS_REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_reg != '0) begin   // r0 is hard zero
            regs[wr_reg] <= wr_data;
        end
    end

    // async read, written value shows up next cycle
    assign rd_a_data = (rd_a_reg == '0) ? '0 : regs[rd_a_reg];
    assign rd_b_data = (rd_b_reg == '0) ? '0 : regs[rd_b_reg];

    a_r0_zero : assert property (@(posedge clk) disable iff (reset)
        regs[0] == '0);

endmodule

//--- source/mips_decode.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module mips_decode (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      instr_valid,
    input  logic [31:0]               instr,
    input  logic [`MIPS_XLEN-1:0]     pc,
    input  logic [`MIPS_XLEN-1:0]     rd_a_data,
    input  logic [`MIPS_XLEN-1:0]     rd_b_data,
    input  logic [`MIPS_XLEN-1:0]     fwd_ex_data,
    input  logic                      ex_valid,
    input  logic                      ex_write,
    input  logic [`MIPS_REG_BITS-1:0] ex_dest,
    input  logic [`MIPS_XLEN-1:0]     ex_data,
    input  logic                      wb_valid,
    input  logic [`MIPS_REG_BITS-1:0] wb_reg,
    input  logic [`MIPS_XLEN-1:0]     wb_data,
    output logic [`MIPS_REG_BITS-1:0] rd_a_reg,
    output logic [`MIPS_REG_BITS-1:0] rd_b_reg,
    output logic                      dec_valid,
    output mips_pkg::alu_op_e         dec_alu_op,
    output mips_pkg::wb_src_e         dec_wb_src,
    output logic                      dec_write,
    output logic [`MIPS_REG_BITS-1:0] dec_dest,
    output logic [`MIPS_XLEN-1:0]     dec_a,
    output logic [`MIPS_XLEN-1:0]     dec_b,
    output logic [`MIPS_XLEN-1:0]     dec_link,
    output logic                      illegal
);

    logic [5:0]                op;
    logic [5:0]                fn;
    logic [`MIPS_REG_BITS-1:0] rs, rt, rd, shamt;
    logic [15:0]               imm;
    mips_pkg::alu_op_e         alu_op;
    mips_pkg::wb_src_e         wb_src;
    logic                      legal, use_imm, is_shift;
    logic [`MIPS_REG_BITS-1:0] dest;
    logic [`MIPS_XLEN-1:0]     imm_ext, a_val, b_val;

    assign op    = instr[31:26];
    assign rs    = instr[25:21];
    assign rt    = instr[20:16];
    assign rd    = instr[15:11];
    assign shamt = instr[10:6];
    assign fn    = instr[5:0];
    assign imm   = instr[15:0];

    assign rd_a_reg = rs;
    assign rd_b_reg = rt;

    // ********************
    // instruction decode
    always_comb begin
        legal    = 1'b1;
        alu_op   = mips_pkg::ALU_ADD;
        wb_src   = mips_pkg::WB_ALU;
        use_imm  = 1'b1;
        is_shift = 1'b0;
        dest     = rt;
        imm_ext  = {16'b0, imm};
        case (op)
            mips_pkg::OP_SPECIAL: begin
                use_imm = 1'b0;
                dest    = rd;
                case (fn)
                    mips_pkg::FN_SLL:  begin alu_op = mips_pkg::ALU_SLL; is_shift = 1'b1; end
                    mips_pkg::FN_SRL:  begin alu_op = mips_pkg::ALU_SRL; is_shift = 1'b1; end
                    mips_pkg::FN_SRA:  begin alu_op = mips_pkg::ALU_SRA; is_shift = 1'b1; end
                    mips_pkg::FN_ADDU: alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:  alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR:  alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::FN_NOR:  alu_op = mips_pkg::ALU_NOR;
                    mips_pkg::FN_SLT:  alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::FN_SLTU: alu_op = mips_pkg::ALU_SLTU;
                    default:           legal  = 1'b0;
                endcase
            end
            mips_pkg::OP_JAL: begin
                wb_src = mips_pkg::WB_LINK;
                dest   = `MIPS_REG_BITS'(`MIPS_LINK_REG);
            end
            mips_pkg::OP_ADDIU: imm_ext = {{16{imm[15]}}, imm};   // sign extended
            mips_pkg::OP_SLTI: begin
                alu_op  = mips_pkg::ALU_SLT;
                imm_ext = {{16{imm[15]}}, imm};
            end
            mips_pkg::OP_ANDI: alu_op = mips_pkg::ALU_AND;
            mips_pkg::OP_ORI:  alu_op = mips_pkg::ALU_OR;
            mips_pkg::OP_XORI: alu_op = mips_pkg::ALU_XOR;
            mips_pkg::OP_LUI:  alu_op = mips_pkg::ALU_LUI;   // alu does the shift
            default:           legal  = 1'b0;
        endcase
    end

    // ********************
    // operand forwarding, youngest producer wins
    function automatic logic [`MIPS_XLEN-1:0] fwd_value(
        input logic [`MIPS_REG_BITS-1:0] idx,
        input logic [`MIPS_XLEN-1:0]     rf_val
    );
        if (idx == '0)
            return rf_val;
        if (dec_valid && dec_write && dec_dest == idx)
            return fwd_ex_data;                     // one slot older
        if (ex_valid && ex_write && ex_dest == idx)
            return ex_data;                         // two slots older
        if (wb_valid && wb_reg == idx)
            return wb_data;                         // being written now
        return rf_val;
    endfunction

    always_comb begin
        a_val = fwd_value(rs, rd_a_data);
        b_val = fwd_value(rt, rd_b_data);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid  <= 1'b0;
            illegal    <= 1'b0;
            dec_alu_op <= mips_pkg::ALU_ADD;
            dec_wb_src <= mips_pkg::WB_ALU;
            dec_write  <= 1'b0;
            dec_dest   <= '0;
            dec_a      <= '0;
            dec_b      <= '0;
            dec_link   <= '0;
        end else begin
            dec_valid  <= instr_valid && legal;
            illegal    <= instr_valid && !legal;
            dec_alu_op <= alu_op;
            dec_wb_src <= wb_src;
            dec_write  <= legal && (dest != '0);    // r0 writes dropped here
            dec_dest   <= dest;
            dec_a      <= is_shift ? b_val : a_val;  // shifts work on rt
            dec_b      <= is_shift ? `MIPS_XLEN'(shamt) : (use_imm ? imm_ext : b_val);
            dec_link   <= pc + `MIPS_XLEN'(8);
        end
    end

    a_valid_xor_illegal : assert property (@(posedge clk) disable iff (reset)
        !(illegal && dec_valid));

endmodule

//--- source/mips_execute.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module mips_execute (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      dec_valid,
    input  mips_pkg::alu_op_e         dec_alu_op,
    input  mips_pkg::wb_src_e         dec_wb_src,
    input  logic                      dec_write,
    input  logic [`MIPS_REG_BITS-1:0] dec_dest,
    input  logic [`MIPS_XLEN-1:0]     dec_a,
    input  logic [`MIPS_XLEN-1:0]     dec_b,
    input  logic [`MIPS_XLEN-1:0]     dec_link,
    output logic [`MIPS_XLEN-1:0]     fwd_ex_data,
    output logic                      ex_valid,
    output logic                      ex_write,
    output logic [`MIPS_REG_BITS-1:0] ex_dest,
    output logic [`MIPS_XLEN-1:0]     ex_data
);

    logic [`MIPS_XLEN-1:0] alu_result;
    logic [4:0]            sh;

    assign sh = dec_b[4:0];

    // ********************
    // alu
    always_comb begin
        case (dec_alu_op)
            mips_pkg::ALU_ADD:  alu_result = dec_a + dec_b;
            mips_pkg::ALU_SUB:  alu_result = dec_a - dec_b;
            mips_pkg::ALU_AND:  alu_result = dec_a & dec_b;
            mips_pkg::ALU_OR:   alu_result = dec_a | dec_b;
            mips_pkg::ALU_XOR:  alu_result = dec_a ^ dec_b;
            mips_pkg::ALU_NOR:  alu_result = ~(dec_a | dec_b);
            mips_pkg::ALU_SLT:  alu_result = `MIPS_XLEN'($signed(dec_a) < $signed(dec_b));
            mips_pkg::ALU_SLTU: alu_result = `MIPS_XLEN'(dec_a < dec_b);
            mips_pkg::ALU_SLL:  alu_result = dec_a << sh;
            mips_pkg::ALU_SRL:  alu_result = dec_a >> sh;
            mips_pkg::ALU_SRA:  alu_result = $signed(dec_a) >>> sh;
            mips_pkg::ALU_LUI:  alu_result = dec_b << 16;
            default:            alu_result = '0;
        endcase
    end

    // also the forward path back into decode
    assign fwd_ex_data = (dec_wb_src == mips_pkg::WB_LINK) ? dec_link : alu_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid <= 1'b0;
            ex_write <= 1'b0;
            ex_dest  <= '0;
            ex_data  <= '0;
        end else begin
            ex_valid <= dec_valid;
            ex_write <= dec_valid && dec_write;
            ex_dest  <= dec_dest;
            ex_data  <= fwd_ex_data;
        end
    end

    a_no_r0_write : assert property (@(posedge clk) disable iff (reset)
        ex_write |-> ex_dest != '0);

endmodule

//--- source/mips_result.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module mips_result (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      ex_valid,
    input  logic                      ex_write,
    input  logic [`MIPS_REG_BITS-1:0] ex_dest,
    input  logic [`MIPS_XLEN-1:0]     ex_data,
    output logic                      wr_en,
    output logic [`MIPS_REG_BITS-1:0] wr_reg,
    output logic [`MIPS_XLEN-1:0]     wr_data
);

    // ********************
    // write-back stage
    // these outputs feed the register file, the forward
    // path in decode and the reporting ports of the core
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_en   <= 1'b0;
            wr_reg  <= '0;
            wr_data <= '0;
        end else begin
            wr_en   <= ex_valid && ex_write;   // only real writes strobe
            wr_reg  <= ex_dest;
            wr_data <= ex_data;
        end
    end

endmodule

//--- source/mips_core.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module mips_core (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      instr_valid,
    input  logic [31:0]               instr,
    input  logic [`MIPS_XLEN-1:0]     pc,
    output logic                      wb_valid,
    output logic [`MIPS_REG_BITS-1:0] wb_reg,
    output logic [`MIPS_XLEN-1:0]     wb_data,
    output logic                      illegal
);

    logic [`MIPS_REG_BITS-1:0] rd_a_reg, rd_b_reg;
    logic [`MIPS_XLEN-1:0]     rd_a_data, rd_b_data;

    // decode -> execute
    logic                      dec_valid, dec_write;
    mips_pkg::alu_op_e         dec_alu_op;
    mips_pkg::wb_src_e         dec_wb_src;
    logic [`MIPS_REG_BITS-1:0] dec_dest;
    logic [`MIPS_XLEN-1:0]     dec_a, dec_b, dec_link;

    // execute -> result
    logic [`MIPS_XLEN-1:0]     fwd_ex_data, ex_data;
    logic                      ex_valid, ex_write;
    logic [`MIPS_REG_BITS-1:0] ex_dest;

    mips_decode u_decode (
        .clk(clk), .reset(reset),
        .instr_valid(instr_valid), .instr(instr), .pc(pc),
        .rd_a_data(rd_a_data), .rd_b_data(rd_b_data),
        .fwd_ex_data(fwd_ex_data),
        .ex_valid(ex_valid), .ex_write(ex_write), .ex_dest(ex_dest), .ex_data(ex_data),
        .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data),
        .rd_a_reg(rd_a_reg), .rd_b_reg(rd_b_reg),
        .dec_valid(dec_valid), .dec_alu_op(dec_alu_op), .dec_wb_src(dec_wb_src),
        .dec_write(dec_write), .dec_dest(dec_dest),
        .dec_a(dec_a), .dec_b(dec_b), .dec_link(dec_link),
        .illegal(illegal)
    );

    mips_register_file u_register_file (
        .clk(clk), .reset(reset),
        .wr_en(wb_valid), .wr_reg(wb_reg), .wr_data(wb_data),
        .rd_a_reg(rd_a_reg), .rd_b_reg(rd_b_reg),
        .rd_a_data(rd_a_data), .rd_b_data(rd_b_data)
    );

    mips_execute u_execute (
        .clk(clk), .reset(reset),
        .dec_valid(dec_valid), .dec_alu_op(dec_alu_op), .dec_wb_src(dec_wb_src),
        .dec_write(dec_write), .dec_dest(dec_dest),
        .dec_a(dec_a), .dec_b(dec_b), .dec_link(dec_link),
        .fwd_ex_data(fwd_ex_data),
        .ex_valid(ex_valid), .ex_write(ex_write), .ex_dest(ex_dest), .ex_data(ex_data)
    );

    mips_result u_result (
        .clk(clk), .reset(reset),
        .ex_valid(ex_valid), .ex_write(ex_write), .ex_dest(ex_dest), .ex_data(ex_data),
        .wr_en(wb_valid), .wr_reg(wb_reg), .wr_data(wb_data)
    );

endmodule

//--- testbench/mips_core_tb.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module mips_core_tb;

    localparam int RESET_CYCLES = 16;

    typedef struct packed {
        int                        cyc;
        logic [`MIPS_REG_BITS-1:0] dst;
        logic [`MIPS_XLEN-1:0]     val;
    } wb_exp_t;

    logic                      clk;
    logic                      reset;
    logic                      instr_valid;
    logic [31:0]               instr;
    logic [`MIPS_XLEN-1:0]     pc;
    logic                      wb_valid;
    logic [`MIPS_REG_BITS-1:0] wb_reg;
    logic [`MIPS_XLEN-1:0]     wb_data;
    logic                      illegal;

    logic [`MIPS_XLEN-1:0] model [`MIPS_REG_COUNT];   // reference register file
    wb_exp_t               wb_q [$];
    int                    ill_q [$];
    int                    cycle = 0;
    int                    strobes = 0;
    integer                seed = 32'h468e;

    mips_core u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_on_error(input string msg);
        $display("Fail %0t: %s", $time, msg);
        $display("** FAIL **");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle > 2 * RESET_CYCLES + 4 * strobes + 200) begin   // grows with the tests
            $display("timeout: the DUT stopped producing the expected strobes");
            $display("** FAIL **");
            $fatal(1);
        end
    end

    // ********************
    // response checks, sampled mid cycle
    always @(negedge clk) begin
        if (!reset && wb_valid) begin
            assert (wb_q.size() > 0) else stop_on_error("wb_valid rose with no write pending");
            assert (wb_reg == wb_q[0].dst && wb_data == wb_q[0].val)
                else stop_on_error($sformatf("wrote r%0d=%h, expected r%0d=%h",
                    wb_reg, wb_data, wb_q[0].dst, wb_q[0].val));
            assert (cycle == wb_q[0].cyc)
                else stop_on_error($sformatf("wb_valid in cycle %0d, expected %0d",
                    cycle, wb_q[0].cyc));
            void'(wb_q.pop_front());
        end
        if (!reset && illegal) begin
            assert (ill_q.size() > 0 && ill_q[0] == cycle)
                else stop_on_error("illegal strobe was not expected in this cycle");
            void'(ill_q.pop_front());
        end
    end

    function automatic logic [31:0] enc_r(input logic [5:0] fn, input logic [4:0] rs, rt, rd, sh);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs, rt,
                                          input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [4:0] rand_reg();
        return 5'd1 + 5'($unsigned($random(seed)) % 30);   // r1..r30
    endfunction

    // ********************
    // strobe one instruction and queue what the ISA says it does
    task automatic issue(input logic [31:0] ins, input logic [31:0] ipc);
        logic [31:0] a, b, simm, zimm, val;
        logic [4:0]  dst, sh;
        logic        ok;
        a    = model[ins[25:21]];
        b    = model[ins[20:16]];
        sh   = ins[10:6];
        simm = {{16{ins[15]}}, ins[15:0]};
        zimm = {16'h0, ins[15:0]};
        dst  = ins[20:16];
        val  = '0;
        ok   = 1'b1;
        case (ins[31:26])
            6'h00: begin
                dst = ins[15:11];
                case (ins[5:0])
                    6'h00: val = b << sh;
                    6'h02: val = b >> sh;
                    6'h03: val = $signed(b) >>> sh;
                    6'h21: val = a + b;
                    6'h23: val = a - b;
                    6'h24: val = a & b;
                    6'h25: val = a | b;
                    6'h26: val = a ^ b;
                    6'h27: val = ~(a | b);
                    6'h2a: val = {31'h0, $signed(a) < $signed(b)};
                    6'h2b: val = {31'h0, a < b};
                    default: ok = 1'b0;
                endcase
            end
            6'h03: begin
                dst = 5'd`MIPS_LINK_REG;
                val = ipc + 32'd8;
            end
            6'h09: val = a + simm;
            6'h0a: val = {31'h0, $signed(a) < $signed(simm)};
            6'h0c: val = a & zimm;
            6'h0d: val = a | zimm;
            6'h0e: val = a ^ zimm;
            6'h0f: val = {ins[15:0], 16'h0};
            default: ok = 1'b0;
        endcase
        @(posedge clk);
        #1;
        instr_valid = 1'b1;
        instr       = ins;
        pc          = ipc;
        strobes++;
        if (!ok) begin
            ill_q.push_back(cycle + 1);
        end else if (dst != 5'd0) begin   // r0 writes never strobe
            model[dst] = val;
            wb_q.push_back('{cycle + 3, dst, val});
        end
    endtask

    task automatic drain();
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        while (wb_q.size() > 0 || ill_q.size() > 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);   // room for a stray strobe
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        reset       = 1'b1;
        wb_q.delete();
        ill_q.delete();
        foreach (model[i]) model[i] = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    // ********************
    // directed tests
    task automatic test_alu();
        logic [5:0] fns [11] = '{6'h00, 6'h02, 6'h03, 6'h21, 6'h23, 6'h24,
                                 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b};
        logic [5:0] ops [6]  = '{6'h09, 6'h0a, 6'h0c, 6'h0d, 6'h0e, 6'h0f};
        for (int r = 1; r < 16; r++) begin
            issue(enc_i(mips_pkg::OP_ADDIU, 5'd0, 5'(r), 16'($random(seed))), '0);
        end
        for (int r = 16; r < 31; r++) begin
            issue(enc_i(mips_pkg::OP_LUI, 5'd0, 5'(r), 16'($random(seed))), '0);
            issue(enc_i(mips_pkg::OP_ORI, 5'(r), 5'(r), 16'($random(seed))), '0);
        end
        repeat (2) begin
            foreach (fns[i]) issue(enc_r(fns[i], rand_reg(), rand_reg(), rand_reg(),
                                         5'($random(seed))), '0);
            foreach (ops[i]) issue(enc_i(ops[i], rand_reg(), rand_reg(), 16'($random(seed))), '0);
        end
        drain();
    endtask

    task automatic test_forwarding();
        logic [4:0] r, o;
        for (int d = 1; d <= 3; d++) begin
            for (int i = 0; i < 9; i++) begin
                r = 5'(8 + i % d);    // written d slots earlier
                o = 5'(20 + i % 4);
                case (i % 3)
                    0: issue(enc_r(mips_pkg::FN_ADDU, r, o, r, 5'd0), '0);
                    1: issue(enc_r(mips_pkg::FN_SUBU, o, r, r, 5'd0), '0);
                    default: issue(enc_i(mips_pkg::OP_ADDIU, r, r, 16'($random(seed))), '0);
                endcase
            end
        end
        drain();
    endtask

    task automatic test_reg_zero();
        issue(enc_i(mips_pkg::OP_ADDIU, rand_reg(), 5'd0, 16'h7fff), '0);
        issue(enc_r(mips_pkg::FN_ADDU, rand_reg(), rand_reg(), 5'd0, 5'd0), '0);
        issue(enc_r(mips_pkg::FN_OR, 5'd0, 5'd0, 5'd3, 5'd0), '0);   // right behind r0 write
        issue(enc_i(mips_pkg::OP_ORI, 5'd0, 5'd4, 16'h1234), '0);
        drain();
    endtask

    task automatic test_jal();
        logic [31:0] jpc;
        jpc = 32'($random(seed)) & 32'hffff_fffc;
        issue({6'(mips_pkg::OP_JAL), 26'($random(seed))}, jpc);
        issue(enc_r(mips_pkg::FN_ADDU, 5'd31, 5'd0, 5'd7, 5'd0), '0);
        drain();
    endtask

    task automatic test_illegal();
        logic [5:0] bad_ops [3] = '{6'h04, 6'h23, 6'h2b};   // beq, lw, sw
        foreach (bad_ops[i]) issue({bad_ops[i], 26'($random(seed))}, '0);
        issue(enc_r(6'h08, rand_reg(), 5'd0, rand_reg(), 5'd0), '0);   // jr
        for (int r = 1; r < 31; r++) begin
            issue(enc_i(mips_pkg::OP_ORI, 5'(r), 5'(r), 16'h0), '0);
        end
        drain();
    endtask

    task automatic test_reset();
        issue(enc_i(mips_pkg::OP_ADDIU, rand_reg(), rand_reg(), 16'($random(seed))), '0);
        issue(enc_r(mips_pkg::FN_XOR, rand_reg(), rand_reg(), rand_reg(), 5'd0), '0);
        issue({6'h23, 26'($random(seed))}, '0);
        apply_reset();                 // in-flight work is dropped
        repeat (8) @(posedge clk);
        for (int r = 1; r < 32; r++) begin
            issue(enc_r(mips_pkg::FN_ADDU, 5'(r), 5'd0, 5'(r), 5'd0), '0);
        end
        drain();
    endtask

    initial begin
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        apply_reset();
        test_alu();
        test_forwarding();
        test_reg_zero();
        test_jal();
        test_illegal();
        test_reset();
        $display("** PASS **");
        $finish;
    end

endmodule

//--- list.f
+incdir+source
source/mips_pkg.sv
source/mips_register_file.sv
source/mips_decode.sv
source/mips_execute.sv
source/mips_result.sv
source/mips_core.sv
testbench/mips_core_tb.sv
